/* verilog/isa_pkg.sv */
// Instruction set definitions for the mini core.
// Holds the opcode map, the instruction word views and the control
// select encodings that decode, ALU and control share.
package isa_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  typedef enum logic [4:0] {
    OP_HALT  = 5'b00000,
    OP_NOP   = 5'b00001,
    OP_J     = 5'b00100,
    OP_JAL   = 5'b00110,
    OP_ADDI  = 5'b01000,
    OP_SUBI  = 5'b01001,
    OP_XORI  = 5'b01010,
    OP_ANDNI = 5'b01011,
    OP_BEQZ  = 5'b01100,
    OP_BNEZ  = 5'b01101,
    OP_SLBI  = 5'b10010,
    OP_LBI   = 5'b11000,
    OP_RTYPE = 5'b11011
  } opcode_e;

  typedef enum logic [1:0] {FUNC_ADD, FUNC_SUB, FUNC_XOR, FUNC_ANDN} func_e;

  // Same 16 bits, four field layouts
  typedef union packed {
    struct packed {
      opcode_e  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      func_e    func;
    } r_fmt;
    struct packed {
      opcode_e    opcode;
      reg_idx_t   rs;
      reg_idx_t   rd;
      logic [4:0] imm5;
    } i1_fmt;
    struct packed {
      opcode_e    opcode;
      reg_idx_t   rs;
      logic [7:0] imm8;
    } i2_fmt;
    struct packed {
      opcode_e     opcode;
      logic [10:0] disp11;
    } j_fmt;
  } instr_u;

  typedef enum logic [1:0] {DEST_R, DEST_I1, DEST_I2, DEST_LINK} dest_sel_e;
  typedef enum logic [2:0] {SEXT5, ZEXT5, SEXT8, ZEXT8, SEXT11} imm_sel_e;
  typedef enum logic [2:0] {
    ALU_ADD, ALU_RSUB, ALU_XOR, ALU_ANDN, ALU_PASS_B, ALU_SLBI
  } alu_op_e;

  localparam reg_idx_t LINK_REG   = 3'd7; // JAL return address register
  localparam int       IMEM_DEPTH = 256;

endpackage

/* verilog/host_pkg.sv */
// APB address map of the host port.
// The host loads instruction words, starts the core and reads back
// status, registers, pc and the retired count at these addresses.
package host_pkg;

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] IMEM_BASE    = 12'h000; // Word n at 4*n
  localparam logic [APB_ADDR_W-1:0] REG_BASE     = 12'h400; // Register n at 0x400 + 4*n
  localparam logic [APB_ADDR_W-1:0] CTRL_ADDR    = 12'h420;
  localparam logic [APB_ADDR_W-1:0] STATUS_ADDR  = 12'h424;
  localparam logic [APB_ADDR_W-1:0] PC_ADDR      = 12'h428;
  localparam logic [APB_ADDR_W-1:0] RETIRED_ADDR = 12'h42c;

  // Status register bits
  localparam int STAT_RUNNING_BIT = 0;
  localparam int STAT_HALTED_BIT  = 1;

endpackage

/* verilog/reg_file.sv */
// Eight 16-bit general registers.
// Two combinational read ports for execute, one for the host, and a
// single write port that takes effect on the clock edge.
`timescale 1ns/10ps

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  isa_pkg::reg_idx_t rs_sel,
  input  isa_pkg::reg_idx_t rt_sel,
  input  isa_pkg::reg_idx_t write_sel,
  input  isa_pkg::word_t    write_data,
  input  logic              write_en,
  input  isa_pkg::reg_idx_t host_sel,
  output isa_pkg::word_t    rs_data,
  output isa_pkg::word_t    rt_data,
  output isa_pkg::word_t    host_data
);
  import isa_pkg::*;

  word_t regs [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) regs[i] <= '0;
    end else if (write_en) begin
      regs[write_sel] <= write_data;
    end
  end

  // No bypass, a same-cycle write shows up next cycle
  assign rs_data   = regs[rs_sel];
  assign rt_data   = regs[rt_sel];
  assign host_data = regs[host_sel];

endmodule

/* verilog/decode.sv */
// Decode stage of the mini core.
// Picks the destination register and its write data, extends the
// immediate fields and holds the register file with its host read port.
`timescale 1ns/10ps

module decode (
  input  logic                  clk,
  input  logic                  reset,
  input  isa_pkg::instr_u       instr,
  input  isa_pkg::word_t        alu_result,
  input  isa_pkg::word_t        link_addr,
  input  logic                  reg_write,
  input  isa_pkg::dest_sel_e    dest_sel,
  input  isa_pkg::imm_sel_e     imm_sel,
  input  isa_pkg::reg_idx_t     host_reg_sel,
  output isa_pkg::word_t        rs_data,
  output isa_pkg::word_t        rt_data,
  output isa_pkg::word_t        immediate,
  output isa_pkg::word_t        host_reg_data
);
  import isa_pkg::*;

  reg_idx_t write_sel;
  word_t    write_data;

  always_comb begin
    case (dest_sel)
      DEST_R:    write_sel = instr.r_fmt.rd;
      DEST_I1:   write_sel = instr.i1_fmt.rd;
      DEST_I2:   write_sel = instr.i2_fmt.rs;  // LBI and SLBI overwrite rs
      default:   write_sel = LINK_REG;
    endcase
  end

  assign write_data = (dest_sel == DEST_LINK) ? link_addr : alu_result;

  // Extender muxes over the union views
  always_comb begin
    case (imm_sel)
      SEXT5:   immediate = {{11{instr.i1_fmt.imm5[4]}}, instr.i1_fmt.imm5};
      ZEXT5:   immediate = {11'b0, instr.i1_fmt.imm5};
      SEXT8:   immediate = {{8{instr.i2_fmt.imm8[7]}}, instr.i2_fmt.imm8};
      ZEXT8:   immediate = {8'b0, instr.i2_fmt.imm8};
      SEXT11:  immediate = {{5{instr.j_fmt.disp11[10]}}, instr.j_fmt.disp11};
      default: immediate = '0;
    endcase
  end

  reg_file regs (
    .clk        (clk),
    .reset      (reset),
    .rs_sel     (instr.r_fmt.rs),
    .rt_sel     (instr.r_fmt.rt),
    .write_sel  (write_sel),
    .write_data (write_data),
    .write_en   (reg_write),
    .host_sel   (host_reg_sel),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .host_data  (host_reg_data)
  );

endmodule

/* verilog/alu.sv */
// Combinational ALU of the mini core.
// Chooses the b operand between rt and the immediate, then applies the
// selected operation. a_zero feeds the branch decision.
`timescale 1ns/10ps

module alu (
  input  isa_pkg::word_t   a,
  input  isa_pkg::word_t   rt_data,
  input  isa_pkg::word_t   immediate,
  input  logic             b_sel,
  input  isa_pkg::alu_op_e alu_op,
  output isa_pkg::word_t   result,
  output logic             a_zero
);
  import isa_pkg::*;

  word_t b;

  assign b = b_sel ? immediate : rt_data; // 1 picks the immediate

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_RSUB:   result = b - a;          // SUB and SUBI subtract rs
      ALU_XOR:    result = a ^ b;
      ALU_ANDN:   result = a & ~b;
      ALU_PASS_B: result = b;
      ALU_SLBI:   result = {a[7:0], 8'b0} | b;
      default:    result = '0;
    endcase
  end

  assign a_zero = (a == '0);

endmodule

/* verilog/core_control.sv */
// Control FSM of the mini core.
// Steps IDLE, FETCH, EXECUTE and HALTED, one cycle per fetch and one per
// execute. In EXECUTE the opcode is decoded into the datapath selects
// and the write, advance and retire strobes.
`timescale 1ns/10ps

module core_control (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  isa_pkg::instr_u    instr,
  input  logic               a_zero,
  output logic               fetch_en,
  output logic               advance,
  output logic               take_target,
  output logic               retire,
  output logic               reg_write,
  output isa_pkg::dest_sel_e dest_sel,
  output isa_pkg::imm_sel_e  imm_sel,
  output isa_pkg::alu_op_e   alu_op,
  output logic               b_sel,
  output logic               running,
  output logic               halted
);
  import isa_pkg::*;

  typedef enum logic [1:0] {IDLE, FETCH, EXECUTE, HALTED} state_e;

  state_e state;
  logic   exec;
  logic   writes_reg;
  logic   branch_taken;
  logic   is_halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE, HALTED: if (start) state <= FETCH;
        FETCH:        state <= EXECUTE;
        EXECUTE:      state <= is_halt ? HALTED : FETCH;
        default:      state <= IDLE;
      endcase
    end
  end

  // Opcode decode, unused opcodes fall through as NOP
  always_comb begin
    writes_reg   = 1'b0;
    branch_taken = 1'b0;
    is_halt      = 1'b0;
    dest_sel     = DEST_R;
    imm_sel      = SEXT5;
    alu_op       = ALU_ADD;
    b_sel        = 1'b0;
    case (instr.r_fmt.opcode)
      OP_RTYPE: begin
        writes_reg = 1'b1;
        case (instr.r_fmt.func)
          FUNC_ADD: alu_op = ALU_ADD;
          FUNC_SUB: alu_op = ALU_RSUB;
          FUNC_XOR: alu_op = ALU_XOR;
          default:  alu_op = ALU_ANDN;
        endcase
      end
      OP_ADDI, OP_SUBI: begin
        writes_reg = 1'b1;
        dest_sel   = DEST_I1;
        b_sel      = 1'b1;
        alu_op     = (instr.r_fmt.opcode == OP_ADDI) ? ALU_ADD : ALU_RSUB;
      end
      OP_XORI, OP_ANDNI: begin
        writes_reg = 1'b1;
        dest_sel   = DEST_I1;
        imm_sel    = ZEXT5;  // Logical immediates are unsigned
        b_sel      = 1'b1;
        alu_op     = (instr.r_fmt.opcode == OP_XORI) ? ALU_XOR : ALU_ANDN;
      end
      OP_LBI: begin
        writes_reg = 1'b1;
        dest_sel   = DEST_I2;
        imm_sel    = SEXT8;
        b_sel      = 1'b1;
        alu_op     = ALU_PASS_B;
      end
      OP_SLBI: begin
        writes_reg = 1'b1;
        dest_sel   = DEST_I2;
        imm_sel    = ZEXT8;
        b_sel      = 1'b1;
        alu_op     = ALU_SLBI;
      end
      OP_BEQZ: begin
        imm_sel      = SEXT8;
        branch_taken = a_zero;
      end
      OP_BNEZ: begin
        imm_sel      = SEXT8;
        branch_taken = ~a_zero;
      end
      OP_J: begin
        imm_sel      = SEXT11;
        branch_taken = 1'b1;
      end
      OP_JAL: begin
        imm_sel      = SEXT11;
        branch_taken = 1'b1;
        writes_reg   = 1'b1;
        dest_sel     = DEST_LINK;
      end
      OP_HALT: is_halt = 1'b1;
      default: ;
    endcase
  end

  assign exec        = (state == EXECUTE);
  assign fetch_en    = (state == FETCH);
  assign reg_write   = exec & writes_reg;
  assign take_target = exec & branch_taken;
  assign advance     = exec & ~is_halt; // HALT keeps pc on itself
  assign retire      = exec;
  assign running     = fetch_en | exec;
  assign halted      = (state == HALTED);

endmodule

/* verilog/pc_counter.sv */
// Program counter and retired-instruction counter.
// pc steps by 2 or loads the branch/jump target when advance is set.
// A start clears both counters for a fresh run.
`timescale 1ns/10ps

module pc_counter (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  logic           advance,
  input  logic           take_target,
  input  isa_pkg::word_t offset,
  input  logic           retire,
  output isa_pkg::word_t pc,
  output isa_pkg::word_t link_addr,
  output isa_pkg::word_t retired
);
  import isa_pkg::*;

  word_t target;

  assign link_addr = pc + 16'd2;
  assign target    = link_addr + offset; // Relative to the next instruction

  always_ff @(posedge clk) begin
    if (reset || start) begin
      pc      <= '0;
      retired <= '0;
    end else begin
      if (advance) pc <= take_target ? target : link_addr;
      if (retire)  retired <= retired + 16'd1;
    end
  end

endmodule

/* verilog/instr_mem.sv */
// Instruction memory, 256 words of 16 bits.
// The host writes words through its port; fetch reads one word per
// fetch cycle and the output holds until the next fetch.
`timescale 1ns/10ps

module instr_mem (
  input  logic                                   clk,
  input  logic                                   imem_we,
  input  logic [$clog2(isa_pkg::IMEM_DEPTH)-1:0] imem_addr,
  input  isa_pkg::word_t                         imem_wdata,
  input  logic                                   fetch_en,
  input  logic [$clog2(isa_pkg::IMEM_DEPTH)-1:0] fetch_addr,
  output isa_pkg::instr_u                        instr
);
  import isa_pkg::*;

  word_t mem [IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (imem_we) mem[imem_addr] <= imem_wdata;
    if (fetch_en) instr <= mem[fetch_addr];  // Registered read
  end

endmodule

/* verilog/host_port.sv */
// APB slave of the mini core, zero wait states.
// Loads instruction memory, issues the start pulse and returns status,
// register, pc and retired-count reads. Illegal accesses get pslverr.
`timescale 1ns/10ps

module host_port (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [host_pkg::APB_ADDR_W-1:0]        paddr,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [host_pkg::APB_DATA_W-1:0]        pwdata,
  input  logic                                   running,
  input  logic                                   halted,
  input  isa_pkg::word_t                         pc,
  input  isa_pkg::word_t                         retired,
  input  isa_pkg::word_t                         host_reg_data,
  output logic [host_pkg::APB_DATA_W-1:0]        prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output logic                                   start,
  output logic                                   imem_we,
  output logic [$clog2(isa_pkg::IMEM_DEPTH)-1:0] imem_addr,
  output isa_pkg::word_t                         imem_wdata,
  output isa_pkg::reg_idx_t                      host_reg_sel
);
  import host_pkg::*;
  import isa_pkg::*;

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  logic access;
  logic imem_hit, reg_hit, ctrl_hit, status_hit, pc_hit, retired_hit;
  logic mapped;
  logic start_req;
  logic [APB_DATA_W-1:0] status;

  assign access = psel & penable;

  // Word address compares, byte offset ignored
  assign imem_hit    = paddr[APB_ADDR_W-1:IMEM_AW+2] == IMEM_BASE[APB_ADDR_W-1:IMEM_AW+2];
  assign reg_hit     = paddr[APB_ADDR_W-1:5] == REG_BASE[APB_ADDR_W-1:5];
  assign ctrl_hit    = paddr[APB_ADDR_W-1:2] == CTRL_ADDR[APB_ADDR_W-1:2];
  assign status_hit  = paddr[APB_ADDR_W-1:2] == STATUS_ADDR[APB_ADDR_W-1:2];
  assign pc_hit      = paddr[APB_ADDR_W-1:2] == PC_ADDR[APB_ADDR_W-1:2];
  assign retired_hit = paddr[APB_ADDR_W-1:2] == RETIRED_ADDR[APB_ADDR_W-1:2];
  assign mapped      = imem_hit | reg_hit | ctrl_hit | status_hit | pc_hit | retired_hit;

  assign pready  = access;
  assign pslverr = access & (~mapped | (pwrite & running & (imem_hit | (ctrl_hit & pwdata[0]))));

  assign imem_we      = access & pwrite & imem_hit & ~running;
  assign imem_addr    = paddr[2 +: IMEM_AW];
  assign imem_wdata   = pwdata[15:0];
  assign host_reg_sel = paddr[4:2];
  assign start_req    = access & pwrite & ctrl_hit & pwdata[0] & ~running;

  always_ff @(posedge clk) begin
    if (reset) start <= 1'b0;
    else       start <= start_req; // One-cycle pulse after the CTRL write
  end

  always_comb begin
    status                   = '0;
    status[STAT_RUNNING_BIT] = running;
    status[STAT_HALTED_BIT]  = halted;
  end

  always_comb begin
    prdata = '0;  // Memory and CTRL read as zero
    if (reg_hit)          prdata = APB_DATA_W'(host_reg_data);
    else if (status_hit)  prdata = status;
    else if (pc_hit)      prdata = APB_DATA_W'(pc);
    else if (retired_hit) prdata = APB_DATA_W'(retired);
  end

endmodule

/* verilog/mini_core.sv */
// Top level of the multicycle mini core.
// Connects the APB host port, instruction memory, control FSM, counters,
// decode stage and ALU. The host drives everything through APB.
`timescale 1ns/10ps

module mini_core (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [host_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [host_pkg::APB_DATA_W-1:0] pwdata,
  output logic [host_pkg::APB_DATA_W-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr
);
  import isa_pkg::*;

  instr_u    instr;
  word_t     pc, link_addr, retired;
  word_t     rs_data, rt_data, immediate, alu_result, host_reg_data, imem_wdata;
  reg_idx_t  host_reg_sel;
  dest_sel_e dest_sel;
  imm_sel_e  imm_sel;
  alu_op_e   alu_op;
  logic      start, running, halted, fetch_en, advance, take_target, retire;
  logic      reg_write, b_sel, a_zero, imem_we;
  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr;

  host_port u_host (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .running(running), .halted(halted),
    .pc(pc), .retired(retired), .host_reg_data(host_reg_data),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .host_reg_sel(host_reg_sel)
  );

  instr_mem u_imem (
    .clk(clk), .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .fetch_en(fetch_en), .fetch_addr(pc[$clog2(IMEM_DEPTH):1]), .instr(instr)
  );

  core_control u_ctrl (
    .clk(clk), .reset(reset), .start(start), .instr(instr), .a_zero(a_zero),
    .fetch_en(fetch_en), .advance(advance), .take_target(take_target),
    .retire(retire), .reg_write(reg_write), .dest_sel(dest_sel),
    .imm_sel(imm_sel), .alu_op(alu_op), .b_sel(b_sel), .running(running),
    .halted(halted)
  );

  pc_counter u_pc (
    .clk(clk), .reset(reset), .start(start), .advance(advance),
    .take_target(take_target), .offset(immediate), .retire(retire),
    .pc(pc), .link_addr(link_addr), .retired(retired)
  );

  decode u_decode (
    .clk(clk), .reset(reset), .instr(instr), .alu_result(alu_result),
    .link_addr(link_addr), .reg_write(reg_write), .dest_sel(dest_sel),
    .imm_sel(imm_sel), .host_reg_sel(host_reg_sel), .rs_data(rs_data),
    .rt_data(rt_data), .immediate(immediate), .host_reg_data(host_reg_data)
  );

  alu u_alu (
    .a(rs_data), .rt_data(rt_data), .immediate(immediate), .b_sel(b_sel),
    .alu_op(alu_op), .result(alu_result), .a_zero(a_zero)
  );

endmodule

/* verification/core_model.svh */
// ISA reference model for the mini core testbench.
// Runs the words in model_mem from pc 0 to HALT on model_regs, which keep
// their values from run to run. Included inside the testbench module.
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int MODEL_STEP_LIMIT = IMEM_DEPTH;

word_t model_mem  [IMEM_DEPTH];
word_t model_regs [8];
word_t model_pc;
word_t model_retired;

// Returns 1 when the program reached HALT within the step limit
function automatic bit model_run();
  word_t w;
  word_t rs_v;
  word_t rt_v;
  word_t link;
  word_t imm5s;
  word_t imm5z;
  word_t imm8s;
  word_t imm8z;
  word_t disp;
  int    step;
  model_pc      = '0;
  model_retired = '0;
  for (step = 0; step < MODEL_STEP_LIMIT; step++) begin
    w     = model_mem[model_pc[8:1]];  // Word index from byte pc
    rs_v  = model_regs[w[10:8]];
    rt_v  = model_regs[w[7:5]];
    link  = model_pc + 16'd2;
    imm5s = {{11{w[4]}}, w[4:0]};
    imm5z = {11'd0, w[4:0]};
    imm8s = {{8{w[7]}}, w[7:0]};
    imm8z = {8'd0, w[7:0]};
    disp  = {{5{w[10]}}, w[10:0]};
    model_retired = model_retired + 16'd1;
    if (w[15:11] == OP_HALT) return 1'b1;  // pc stays on the HALT
    model_pc = link;
    case (w[15:11])
      OP_RTYPE: begin
        case (w[1:0])
          FUNC_ADD: model_regs[w[4:2]] = rs_v + rt_v;
          FUNC_SUB: model_regs[w[4:2]] = rt_v - rs_v;
          FUNC_XOR: model_regs[w[4:2]] = rs_v ^ rt_v;
          default:  model_regs[w[4:2]] = rs_v & ~rt_v;
        endcase
      end
      OP_ADDI:  model_regs[w[7:5]] = rs_v + imm5s;
      OP_SUBI:  model_regs[w[7:5]] = imm5s - rs_v;
      OP_XORI:  model_regs[w[7:5]] = rs_v ^ imm5z;
      OP_ANDNI: model_regs[w[7:5]] = rs_v & ~imm5z;
      OP_LBI:   model_regs[w[10:8]] = imm8s;
      OP_SLBI:  model_regs[w[10:8]] = {rs_v[7:0], 8'h00} | imm8z;
      OP_BEQZ:  if (rs_v == 16'd0) model_pc = link + imm8s;
      OP_BNEZ:  if (rs_v != 16'd0) model_pc = link + imm8s;
      OP_J:     model_pc = link + disp;
      OP_JAL: begin
        model_regs[LINK_REG] = link;
        model_pc             = link + disp;
      end
      default: ;  // NOP and spare opcodes
    endcase
  end
  return 1'b0;
endfunction

`endif

/* verification/mini_core_tb.sv */
// Testbench for the mini core.
// Loads random programs over APB, runs each to HALT twice and compares
// registers, pc and retired count against the ISA model. Also covers the
// reset state and the pslverr responses of the host port.
`timescale 1ns/10ps

module mini_core_tb;
  import isa_pkg::*;
  import host_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_PROGS    = 20;
  localparam int MAX_LEN      = 60;
  localparam int PROG_CYCLES  = 900;  // 256-word load, two runs, readback
  localparam int CYCLE_LIMIT  = (NUM_PROGS + 2) * PROG_CYCLES;
  localparam int unsigned RAND_SEED = 32'hf4d6_8dd3;

  logic                  clk = 1'b0;
  logic                  reset;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  int                    value_errors;
  int                    other_errors;
  int                    cycle_count = 0;
  logic [APB_DATA_W-1:0] rdata;
  logic                  err;

  `include "core_model.svh"

  mini_core i_mini_core (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the core never reached HALT", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: retired got %0d expected %0d", $time, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_status(input logic [APB_DATA_W-1:0] got,
                              input logic [APB_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: status got %h expected %h", $time, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // Runs from a falling edge to the falling edge after the access
  task automatic bus_cycle(input logic write, input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] data,
                           output logic [APB_DATA_W-1:0] rd, output logic slverr);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);  // Sample in the middle of the low phase
    rd     = prdata;
    slverr = pslverr;
    if (pready !== 1'b1) begin
      $display("APB access to %h at %0t finished without pready", addr, $time);
      other_errors++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic host_write(input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] data, input logic exp_err);
    logic [APB_DATA_W-1:0] unused_rd;
    logic                  slverr;
    bus_cycle(1'b1, addr, data, unused_rd, slverr);
    check_resp($sformatf("pslverr write %h", addr), slverr, exp_err);
  endtask

  task automatic host_read(input logic [APB_ADDR_W-1:0] addr,
                           output logic [APB_DATA_W-1:0] data);
    logic slverr;
    bus_cycle(1'b0, addr, '0, data, slverr);
    check_resp($sformatf("pslverr read %h", addr), slverr, 1'b0);
  endtask

  // Kept instructions only with small positive flow offsets
  function automatic word_t random_instr(input bit with_flow);
    word_t w;
    int    kind;
    w    = word_t'($urandom);
    kind = with_flow ? $urandom_range(0, 9) : $urandom_range(0, 5);
    case (kind)
      0: w[15:11] = OP_RTYPE;
      1: begin
        case ($urandom_range(0, 3))
          0:       w[15:11] = OP_ADDI;
          1:       w[15:11] = OP_SUBI;
          2:       w[15:11] = OP_XORI;
          default: w[15:11] = OP_ANDNI;
        endcase
      end
      2: w[15:11] = OP_LBI;
      3: w[15:11] = OP_SLBI;
      4: w[15:11] = OP_NOP;
      5: w[15:11] = 5'b10000 | 5'($urandom_range(0, 1));  // Dropped ST/LD act as NOP
      6, 7: begin
        w[15:11] = (kind == 6) ? OP_BEQZ : OP_BNEZ;
        w[7:0]   = 8'(2 * $urandom_range(0, 7));
      end
      default: begin
        w[15:11] = (kind == 8) ? OP_J : OP_JAL;
        w[10:0]  = 11'(2 * $urandom_range(0, 7));
      end
    endcase
    return w;
  endfunction

  task automatic build_program(input bit with_flow, input int len);
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      if (i < len) model_mem[i] = random_instr(with_flow);
      else         model_mem[i] = {OP_HALT, 3'b000, 8'(i)};  // HALT tagged by address
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      host_write(IMEM_BASE + 12'(4 * i), {16'h0000, model_mem[i]}, 1'b0);
    end
  endtask

  task automatic wait_for_halt();
    logic [APB_DATA_W-1:0] status;
    status = '0;
    while (status[STAT_HALTED_BIT] !== 1'b1) host_read(STATUS_ADDR, status);
  endtask

  task automatic compare_state();
    logic [APB_DATA_W-1:0] data;
    logic [APB_DATA_W-1:0] exp_status;
    exp_status                  = '0;
    exp_status[STAT_HALTED_BIT] = 1'b1;
    host_read(STATUS_ADDR, data);
    check_status(data, exp_status);
    for (int i = 0; i < 8; i++) begin
      host_read(REG_BASE + 12'(4 * i), data);
      check_word($sformatf("r%0d", i), data[15:0], model_regs[i]);
    end
    host_read(PC_ADDR, data);
    check_word("pc", data[15:0], model_pc);
    host_read(RETIRED_ADDR, data);
    check_count(data[15:0], model_retired);
  endtask

  task automatic run_and_compare();
    host_write(CTRL_ADDR, 32'h1, 1'b0);
    wait_for_halt();
    if (!model_run()) begin
      $display("Model did not reach HALT within %0d steps", MODEL_STEP_LIMIT);
      other_errors++;
    end
    compare_state();
  endtask

  initial begin
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < 8; i++) model_regs[i] = '0;
    void'($urandom(RAND_SEED));
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Idle after reset
    host_read(STATUS_ADDR, rdata);
    check_status(rdata, '0);
    for (int i = 0; i < 8; i++) begin
      host_read(REG_BASE + 12'(4 * i), rdata);
      check_word($sformatf("r%0d", i), rdata[15:0], 16'h0000);
    end

    // Straight-line program with refused writes while running
    build_program(1'b0, 20);
    load_program();
    host_write(CTRL_ADDR, 32'h1, 1'b0);
    host_write(IMEM_BASE + 12'(4 * 15), 32'h0000_c7ff, 1'b1);  // LBI r7 not yet fetched
    host_write(CTRL_ADDR, 32'h1, 1'b1);
    bus_cycle(1'b0, 12'h430, '0, rdata, err);
    check_resp("pslverr unmapped read", err, 1'b1);
    wait_for_halt();
    if (!model_run()) begin
      $display("Model did not reach HALT on the straight-line program");
      other_errors++;
    end
    compare_state();

    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program(1'b1, $urandom_range(8, MAX_LEN));
      load_program();
      run_and_compare();
      run_and_compare();  // Restart from HALTED with the registers carried over
    end

    $display("Checks finished: %0d value errors, %0d other errors",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* mini_core.f */
+incdir+verification
verilog/isa_pkg.sv
verilog/host_pkg.sv
verilog/reg_file.sv
verilog/decode.sv
verilog/alu.sv
verilog/core_control.sv
verilog/pc_counter.sv
verilog/instr_mem.sv
verilog/host_port.sv
verilog/mini_core.sv
verification/mini_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mini_core_tb -f mini_core.f \
  --Mdir obj_dir -o mini_core_sim
./obj_dir/mini_core_sim > sim.log
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1
